// File: sim.f
+incdir+dv
src/cache_mem_pkg.sv
src/sp_ram.sv
src/cache_mem_ctrl.sv
src/tag_array.sv
src/data_array.sv
src/cache_mem_top.sv
dv/cache_mem_tb.sv

// File: Bender.yml
package:
  name: cache_mem

sources:
  - files:
      - src/cache_mem_pkg.sv
      - src/sp_ram.sv
      - src/cache_mem_ctrl.sv
      - src/tag_array.sv
      - src/data_array.sv
      - src/cache_mem_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/cache_mem_tb.sv

// File: dv/cache_mem_tests.svh
`ifndef CACHE_MEM_TESTS_SVH
`define CACHE_MEM_TESTS_SVH

logic [cache_mem_pkg::PLEN-1:0] adr_a, adr_b;  // way 0 and way 1 lines of one set
logic [cache_mem_pkg::PLEN-1:0] filled [$];     // every address filled so far

function automatic logic [cache_mem_pkg::IDX_BITS-1:0] idx_of(input logic [31:0] adr);
  return adr[cache_mem_pkg::OFFS_BITS +: cache_mem_pkg::IDX_BITS];
endfunction

function automatic logic [cache_mem_pkg::TAG_BITS-1:0] tag_of(input logic [31:0] adr);
  return adr[cache_mem_pkg::OFFS_BITS + cache_mem_pkg::IDX_BITS +: cache_mem_pkg::TAG_BITS];
endfunction

//////////////////////////////////////////////////
// bus operations with a one cycle strobe

task automatic fill_line(input logic [31:0] adr, input int way, input logic dirty);
  fill_i           = 1'b1;
  fill_adr_i       = adr;
  fill_way_i       = '0;
  fill_way_i[way]  = 1'b1;
  fill_line_i      = {rand_word(), rand_word(), rand_word(), rand_word()};
  fill_dirty_i     = dirty;
  @(negedge clk_i);  // written at this edge
  fill_i           = 1'b0;
  model_tag[way][idx_of(adr)]   = tag_of(adr);
  model_line[way][idx_of(adr)]  = fill_line_i;
  model_valid[way][idx_of(adr)] = 1'b1;
  model_dirty[way][idx_of(adr)] = dirty;
  filled.push_back(adr);
endtask

task automatic wb_write(input logic [31:0] adr, input int way, input logic [3:0] be);
  int word;
  word          = adr[3:2];  // word select
  wb_we_i       = 1'b1;
  wb_adr_i      = adr;
  wb_way_i      = '0;
  wb_way_i[way] = 1'b1;
  wb_be_i       = be;
  wb_data_i     = rand_word();
  @(negedge clk_i);
  wb_we_i       = 1'b0;
  for (int b = 0; b < 4; b++)
    if (be[b])
      model_line[way][idx_of(adr)][word*32 + b*8 +: 8] = wb_data_i[b*8 +: 8];
  model_dirty[way][idx_of(adr)] = 1'b1;  // any cpu write dirties
endtask

// expected from the model before the request
task automatic lookup_check(input string name, input logic [31:0] adr);
  logic [cache_mem_pkg::WAYS-1:0]     exp_ways;
  logic [cache_mem_pkg::BLK_BITS-1:0] exp_line;
  logic                               exp_dirty;
  exp_ways  = '0;
  exp_line  = '0;
  exp_dirty = 1'b0;
  for (int w = 0; w < cache_mem_pkg::WAYS; w++)
    if (model_valid[w][idx_of(adr)] && model_tag[w][idx_of(adr)] == tag_of(adr))
    begin
      exp_ways[w] = 1'b1;
      exp_line    = model_line[w][idx_of(adr)];
      exp_dirty   = model_dirty[w][idx_of(adr)];
    end
  rd_req_i = 1'b1;
  rd_adr_i = adr;
  @(negedge clk_i);
  rd_req_i = 1'b0;
  @(negedge clk_i);  // results registered two edges on
  check_eq({name, " hit"}, |exp_ways, hit_o);
  check_eq({name, " ways"}, exp_ways, ways_hit_o);
  if (|exp_ways)
  begin
    check_eq({name, " line"}, exp_line, line_o);
    check_eq({name, " dirty"}, exp_dirty, dirty_o);
  end
endtask

task automatic evict_check(input string name, input logic [3:0] idx, input int way);
  evict_req_i      = 1'b1;
  evict_idx_i      = idx;
  evict_way_i      = '0;
  evict_way_i[way] = 1'b1;
  @(negedge clk_i);
  evict_req_i      = 1'b0;
  @(negedge clk_i);
  check_eq({name, " adr"}, {model_tag[way][idx], idx, 4'h0}, evict_adr_o);  // line aligned
  check_eq({name, " line"}, model_line[way][idx], evict_line_o);
  check_eq({name, " dirty"}, model_dirty[way][idx], evict_dirty_o);
endtask

//////////////////////////////////////////////////
// directed tests

task automatic reset_lookup_miss();
  repeat (4) lookup_check("reset miss", rand_word());
endtask

task automatic fill_way0_lookup();
  logic [31:0] r;
  r     = rand_word();
  adr_a = rand_word();
  fill_line(adr_a, 0, r[0]);
  lookup_check("fill way0", adr_a);
endtask

task automatic fill_way1_lookup();
  logic [31:0] r, adr_c;
  r     = rand_word();
  adr_b = adr_a ^ {r[23:0] | 24'h1, 8'h00};  // same set with another tag
  fill_line(adr_b, 1, r[31]);
  lookup_check("way0 kept", adr_a);
  lookup_check("fill way1", adr_b);
  do
  begin
    r     = rand_word();
    adr_c = {r[31:8], adr_a[7:0]};
  end
  while (tag_of(adr_c) == tag_of(adr_a) || tag_of(adr_c) == tag_of(adr_b));
  lookup_check("third tag miss", adr_c);
endtask

task automatic wb_write_lookup();
  logic [31:0] r;
  r = rand_word();
  wb_write({adr_a[31:4], r[3:2], 2'b00}, 0, r[7:4]);  // random word and bytes
  lookup_check("wb way0", adr_a);
  wb_write({adr_b[31:4], r[9:8], 2'b00}, 1, r[13:10]);
  lookup_check("wb way1", adr_b);
endtask

task automatic evict_both_ways();
  evict_check("evict way0", idx_of(adr_a), 0);
  evict_check("evict way1", idx_of(adr_b), 1);
endtask

task automatic invalidate_all_miss();
  logic [31:0] r;
  repeat (3)
  begin
    r = rand_word();
    fill_line(r, r[8], r[9]);  // other sets too
  end
  invalidate_all_i = 1'b1;
  @(negedge clk_i);
  invalidate_all_i = 1'b0;
  check_eq("invalidate hit", 1'b0, hit_o);  // last lookup hit, cleared by the strobe
  check_eq("invalidate ways", '0, ways_hit_o);
  for (int w = 0; w < cache_mem_pkg::WAYS; w++)
    for (int s = 0; s < cache_mem_pkg::SETS; s++)
      model_valid[w][s] = 1'b0;
  for (int i = 0; i < filled.size(); i++)
    lookup_check("invalidate", filled[i]);
endtask

`endif

// File: dv/cache_mem_tb.sv
`timescale 1ns/1ps

module cache_mem_tb;

  localparam int TIMEOUT_CYCLES = 2000;  // far above the directed sequence of about 50 cycles

  logic                                  clk_i, rst_ni;
  logic                                  rd_req_i, fill_i, fill_dirty_i, wb_we_i;
  logic                                  evict_req_i, invalidate_all_i;
  logic [cache_mem_pkg::PLEN-1:0]        rd_adr_i, fill_adr_i, wb_adr_i;
  logic [cache_mem_pkg::WAYS-1:0]        fill_way_i, wb_way_i, evict_way_i;
  logic [cache_mem_pkg::BLK_BITS-1:0]    fill_line_i;
  logic [cache_mem_pkg::XLEN/8-1:0]      wb_be_i;
  logic [cache_mem_pkg::XLEN-1:0]        wb_data_i;
  logic [cache_mem_pkg::IDX_BITS-1:0]    evict_idx_i;
  logic                                  hit_o, dirty_o, evict_dirty_o;  // dut outputs
  logic [cache_mem_pkg::WAYS-1:0]        ways_hit_o;
  logic [cache_mem_pkg::BLK_BITS-1:0]    line_o, evict_line_o;
  logic [cache_mem_pkg::PLEN-1:0]        evict_adr_o;

  // reference model per way and set
  logic [cache_mem_pkg::TAG_BITS-1:0]    model_tag   [cache_mem_pkg::WAYS][cache_mem_pkg::SETS];
  logic [cache_mem_pkg::BLK_BITS-1:0]    model_line  [cache_mem_pkg::WAYS][cache_mem_pkg::SETS];
  logic                                  model_valid [cache_mem_pkg::WAYS][cache_mem_pkg::SETS];
  logic                                  model_dirty [cache_mem_pkg::WAYS][cache_mem_pkg::SETS];

  logic [31:0] lcg_state = 32'd30;  // seed
  int          cycles    = 0;

  cache_mem_top uut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;  // 40 ns period
  end

  //////////////////////////////////////////////////
  // random source and compare

  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_eq(input string name, input logic [cache_mem_pkg::BLK_BITS-1:0] expected,
                          input logic [cache_mem_pkg::BLK_BITS-1:0] actual);
    if (expected !== actual)
    begin
      $display("error %s expected %0h actual %0h", name, expected, actual);
      $display("tests failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // run limit
  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout, the test sequence did not finish in %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $fatal(1, "stopped by the cycle limit");
    end
  end

  `include "cache_mem_tests.svh"

  //////////////////////////////////////////////////
  // sequence
  initial
  begin
    rst_ni           = 1'b0;
    rd_req_i         = 1'b0;
    rd_adr_i         = '0;
    fill_i           = 1'b0;
    fill_adr_i       = '0;
    fill_way_i       = '0;
    fill_line_i      = '0;
    fill_dirty_i     = 1'b0;
    wb_we_i          = 1'b0;
    wb_adr_i         = '0;
    wb_way_i         = '0;
    wb_be_i          = '0;
    wb_data_i        = '0;
    evict_req_i      = 1'b0;
    evict_idx_i      = '0;
    evict_way_i      = '0;
    invalidate_all_i = 1'b0;
    for (int w = 0; w < cache_mem_pkg::WAYS; w++)
      for (int s = 0; s < cache_mem_pkg::SETS; s++)
      begin
        model_valid[w][s] = 1'b0;
        model_dirty[w][s] = 1'b0;
      end
    repeat (5) @(negedge clk_i);  // reset for 5 cycles
    rst_ni = 1'b1;
    @(negedge clk_i);
    reset_lookup_miss();
    fill_way0_lookup();
    fill_way1_lookup();
    wb_write_lookup();
    evict_both_ways();
    invalidate_all_miss();
    $display("all tests passed");
    $finish;
  end

endmodule

// File: src/cache_mem_top.sv
`timescale 1ns/1ps

module cache_mem_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // lookup
  input  logic                                    rd_req_i,
  input  logic [cache_mem_pkg::PLEN-1:0]          rd_adr_i,
  output logic                                    hit_o,
  output logic [cache_mem_pkg::WAYS-1:0]          ways_hit_o,
  output logic                                    dirty_o,
  output logic [cache_mem_pkg::BLK_BITS-1:0]      line_o,
  // fill from bus interface
  input  logic                                    fill_i,
  input  logic [cache_mem_pkg::PLEN-1:0]          fill_adr_i,
  input  logic [cache_mem_pkg::WAYS-1:0]          fill_way_i,
  input  logic [cache_mem_pkg::BLK_BITS-1:0]      fill_line_i,
  input  logic                                    fill_dirty_i,
  // write buffer
  input  logic                                    wb_we_i,
  input  logic [cache_mem_pkg::PLEN-1:0]          wb_adr_i,
  input  logic [cache_mem_pkg::WAYS-1:0]          wb_way_i,
  input  logic [cache_mem_pkg::XLEN/8-1:0]        wb_be_i,
  input  logic [cache_mem_pkg::XLEN-1:0]          wb_data_i,
  // eviction
  input  logic                                    evict_req_i,
  input  logic [cache_mem_pkg::IDX_BITS-1:0]      evict_idx_i,
  input  logic [cache_mem_pkg::WAYS-1:0]          evict_way_i,
  output logic [cache_mem_pkg::PLEN-1:0]          evict_adr_o,
  output logic [cache_mem_pkg::BLK_BITS-1:0]      evict_line_o,
  output logic                                    evict_dirty_o,
  input  logic                                    invalidate_all_i
);

  logic [cache_mem_pkg::IDX_BITS-1:0]  ram_idx, evict_idx_q;
  logic [cache_mem_pkg::WAYS-1:0]      tag_we, dat_we, evict_way_q, hit_way;
  logic [cache_mem_pkg::BLK_BYTES-1:0] dat_be;
  logic [cache_mem_pkg::TAG_BITS-1:0]  lookup_tag, fill_tag;
  logic                                dat_sel_wb, latch_rd, latch_evict;

  cache_mem_ctrl u_ctrl (
    .clk_i, .rst_ni, .rd_req_i, .rd_adr_i, .fill_i, .fill_adr_i, .fill_way_i,
    .wb_we_i, .wb_adr_i, .wb_way_i, .wb_be_i, .evict_req_i, .evict_idx_i, .evict_way_i,
    .ram_idx_o (ram_idx), .tag_we_o (tag_we), .dat_we_o (dat_we), .dat_be_o (dat_be),
    .dat_sel_wb_o (dat_sel_wb), .lookup_tag_o (lookup_tag), .fill_tag_o (fill_tag),
    .latch_rd_o (latch_rd), .latch_evict_o (latch_evict),
    .evict_way_q_o (evict_way_q), .evict_idx_q_o (evict_idx_q)
  );

  tag_array u_tag (
    .clk_i, .rst_ni, .ram_idx_i (ram_idx), .tag_we_i (tag_we), .dat_we_i (dat_we),
    .fill_tag_i (fill_tag), .fill_dirty_i, .lookup_tag_i (lookup_tag),
    .latch_rd_i (latch_rd), .latch_evict_i (latch_evict),
    .evict_way_q_i (evict_way_q), .evict_idx_q_i (evict_idx_q), .invalidate_all_i,
    .hit_way_o (hit_way), .hit_o, .ways_hit_o, .dirty_o, .evict_adr_o, .evict_dirty_o
  );

  data_array u_data (
    .clk_i, .ram_idx_i (ram_idx), .dat_we_i (dat_we), .dat_be_i (dat_be),
    .dat_sel_wb_i (dat_sel_wb), .fill_line_i, .wb_data_i, .hit_way_i (hit_way),
    .latch_rd_i (latch_rd), .latch_evict_i (latch_evict), .evict_way_q_i (evict_way_q),
    .line_o, .evict_line_o
  );

endmodule

// File: src/data_array.sv
`timescale 1ns/1ps

module data_array (
  input  logic                                    clk_i,
  input  logic [cache_mem_pkg::IDX_BITS-1:0]      ram_idx_i,
  input  logic [cache_mem_pkg::WAYS-1:0]          dat_we_i,
  input  logic [cache_mem_pkg::BLK_BYTES-1:0]     dat_be_i,
  input  logic                                    dat_sel_wb_i,
  input  logic [cache_mem_pkg::BLK_BITS-1:0]      fill_line_i,
  input  logic [cache_mem_pkg::XLEN-1:0]          wb_data_i,
  input  logic [cache_mem_pkg::WAYS-1:0]          hit_way_i,
  input  logic                                    latch_rd_i,
  input  logic                                    latch_evict_i,
  input  logic [cache_mem_pkg::WAYS-1:0]          evict_way_q_i,
  output logic [cache_mem_pkg::BLK_BITS-1:0]      line_o,
  output logic [cache_mem_pkg::BLK_BITS-1:0]      evict_line_o
);

  logic [cache_mem_pkg::BLK_BITS-1:0]                          dat_in;
  logic [cache_mem_pkg::WAYS-1:0][cache_mem_pkg::BLK_BITS-1:0] dat_out;

  // and-or select of one line, sel is one-hot or zero
  function automatic logic [cache_mem_pkg::BLK_BITS-1:0] way_mux(
    input logic [cache_mem_pkg::WAYS-1:0][cache_mem_pkg::BLK_BITS-1:0] lines,
    input logic [cache_mem_pkg::WAYS-1:0]                              sel
  );
    logic [cache_mem_pkg::BLK_BITS-1:0] acc;
    acc = '0;
    for (int w = 0; w < cache_mem_pkg::WAYS; w++)
      acc |= lines[w] & {cache_mem_pkg::BLK_BITS{sel[w]}};
    return acc;
  endfunction

  // cpu word copied to every slot, byte enables pick the real one
  assign dat_in = dat_sel_wb_i ?
                  {(cache_mem_pkg::BLK_BITS/cache_mem_pkg::XLEN){wb_data_i}} : fill_line_i;

  //////////////////////////////////////////////////
  // one data ram per way, shared index
  for (genvar w = 0; w < cache_mem_pkg::WAYS; w++)
  begin : gen_way
    sp_ram #(
      .ABITS  ( cache_mem_pkg::IDX_BITS ),
      .DBITS  ( cache_mem_pkg::BLK_BITS )
    ) u_data_ram (
      .clk_i  ( clk_i       ),
      .addr_i ( ram_idx_i   ),
      .we_i   ( dat_we_i[w] ),
      .be_i   ( dat_be_i    ),
      .din_i  ( dat_in      ),
      .dout_o ( dat_out[w]  )
    );
  end

  // result registers hold until their next strobe
  always_ff @(posedge clk_i)
  begin
    if (latch_rd_i)
    begin
      line_o <= way_mux(dat_out, hit_way_i);  // zero on a miss
    end
    if (latch_evict_i)
    begin
      evict_line_o <= way_mux(dat_out, evict_way_q_i);
    end
  end

endmodule

// File: src/tag_array.sv
`timescale 1ns/1ps

module tag_array (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic [cache_mem_pkg::IDX_BITS-1:0]      ram_idx_i,
  input  logic [cache_mem_pkg::WAYS-1:0]          tag_we_i,
  input  logic [cache_mem_pkg::WAYS-1:0]          dat_we_i,
  input  logic [cache_mem_pkg::TAG_BITS-1:0]      fill_tag_i,
  input  logic                                    fill_dirty_i,
  input  logic [cache_mem_pkg::TAG_BITS-1:0]      lookup_tag_i,
  input  logic                                    latch_rd_i,
  input  logic                                    latch_evict_i,
  input  logic [cache_mem_pkg::WAYS-1:0]          evict_way_q_i,
  input  logic [cache_mem_pkg::IDX_BITS-1:0]      evict_idx_q_i,
  input  logic                                    invalidate_all_i,
  output logic [cache_mem_pkg::WAYS-1:0]          hit_way_o,
  output logic                                    hit_o,
  output logic [cache_mem_pkg::WAYS-1:0]          ways_hit_o,
  output logic                                    dirty_o,
  output logic [cache_mem_pkg::PLEN-1:0]          evict_adr_o,
  output logic                                    evict_dirty_o
);

  logic [cache_mem_pkg::WAYS-1:0][cache_mem_pkg::TAG_BITS-1:0] tag_out;
  logic [cache_mem_pkg::WAYS-1:0][cache_mem_pkg::SETS-1:0]     valid_q, dirty_q;
  logic [cache_mem_pkg::IDX_BITS-1:0] idx_q;        // index of the pending lookup
  logic [cache_mem_pkg::WAYS-1:0]     way_dirty, evict_way_dirty;
  logic [cache_mem_pkg::TAG_BITS-1:0] evict_tag_mux, evict_tag_q;
  logic [cache_mem_pkg::IDX_BITS-1:0] evict_idx_r;
  cache_mem_pkg::cache_addr_u         evict_a;

  for (genvar w = 0; w < cache_mem_pkg::WAYS; w++)
  begin : gen_way
    sp_ram #(
      .ABITS  ( cache_mem_pkg::IDX_BITS ),
      .DBITS  ( cache_mem_pkg::TAG_BITS )
    ) u_tag_ram (
      .clk_i  ( clk_i       ),
      .addr_i ( ram_idx_i   ),
      .we_i   ( tag_we_i[w] ),
      .be_i   ( '1          ),  // whole tag
      .din_i  ( fill_tag_i  ),
      .dout_o ( tag_out[w]  )
    );

    assign hit_way_o[w]       = valid_q[w][idx_q] & (tag_out[w] == lookup_tag_i);
    assign way_dirty[w]       = dirty_q[w][idx_q];
    assign evict_way_dirty[w] = valid_q[w][evict_idx_q_i] & dirty_q[w][evict_idx_q_i];
  end

  //////////////////////////////////////////////////
  // valid and dirty flags, one per way and set
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
      dirty_q <= '0;
    end
    else
    begin
      for (int w = 0; w < cache_mem_pkg::WAYS; w++)
      begin
        if (invalidate_all_i)  valid_q[w]            <= '0;
        else if (tag_we_i[w])  valid_q[w][ram_idx_i] <= 1'b1;
        if (tag_we_i[w])       dirty_q[w][ram_idx_i] <= fill_dirty_i;
        else if (dat_we_i[w])  dirty_q[w][ram_idx_i] <= 1'b1;  // cpu word write
      end
    end
  end

  always_ff @(posedge clk_i)
    idx_q <= ram_idx_i;  // follows the ram address register

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      hit_o      <= 1'b0;
      ways_hit_o <= '0;
      dirty_o    <= 1'b0;
    end
    else if (invalidate_all_i)
    begin
      hit_o      <= 1'b0;
      ways_hit_o <= '0;
    end
    else if (latch_rd_i)
    begin
      hit_o      <= |hit_way_o;
      ways_hit_o <= hit_way_o;
      dirty_o    <= |(hit_way_o & way_dirty);
    end
  end

  //////////////////////////////////////////////////
  // victim tag, and-or on the one-hot way
  always_comb
  begin
    evict_tag_mux = '0;
    for (int w = 0; w < cache_mem_pkg::WAYS; w++)
      evict_tag_mux |= tag_out[w] & {cache_mem_pkg::TAG_BITS{evict_way_q_i[w]}};
  end

  always_ff @(posedge clk_i)
  begin
    if (latch_evict_i)
    begin
      evict_tag_q   <= evict_tag_mux;
      evict_idx_r   <= evict_idx_q_i;
      evict_dirty_o <= |(evict_way_q_i & evict_way_dirty);
    end
  end

  // line aligned, offset bits zero
  always_comb
  begin
    evict_a.f.tag      = evict_tag_q;
    evict_a.f.idx      = evict_idx_r;
    evict_a.f.word     = '0;
    evict_a.f.byte_sel = '0;
  end

  assign evict_adr_o = evict_a.flat;

endmodule

// File: src/cache_mem_ctrl.sv
`timescale 1ns/1ps

module cache_mem_ctrl (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    rd_req_i,
  input  logic [cache_mem_pkg::PLEN-1:0]          rd_adr_i,
  input  logic                                    fill_i,
  input  logic [cache_mem_pkg::PLEN-1:0]          fill_adr_i,
  input  logic [cache_mem_pkg::WAYS-1:0]          fill_way_i,
  input  logic                                    wb_we_i,
  input  logic [cache_mem_pkg::PLEN-1:0]          wb_adr_i,
  input  logic [cache_mem_pkg::WAYS-1:0]          wb_way_i,
  input  logic [cache_mem_pkg::XLEN/8-1:0]        wb_be_i,
  input  logic                                    evict_req_i,
  input  logic [cache_mem_pkg::IDX_BITS-1:0]      evict_idx_i,
  input  logic [cache_mem_pkg::WAYS-1:0]          evict_way_i,
  output logic [cache_mem_pkg::IDX_BITS-1:0]      ram_idx_o,
  output logic [cache_mem_pkg::WAYS-1:0]          tag_we_o,
  output logic [cache_mem_pkg::WAYS-1:0]          dat_we_o,
  output logic [cache_mem_pkg::BLK_BYTES-1:0]     dat_be_o,
  output logic                                    dat_sel_wb_o,
  output logic [cache_mem_pkg::TAG_BITS-1:0]      lookup_tag_o,
  output logic [cache_mem_pkg::TAG_BITS-1:0]      fill_tag_o,
  output logic                                    latch_rd_o,
  output logic                                    latch_evict_o,
  output logic [cache_mem_pkg::WAYS-1:0]          evict_way_q_o,
  output logic [cache_mem_pkg::IDX_BITS-1:0]      evict_idx_q_o
);

  cache_mem_pkg::cache_addr_u rd_a, fill_a, wb_a;
  logic                       evict_go, rd_go, wb_go;

  assign rd_a.flat   = rd_adr_i;
  assign fill_a.flat = fill_adr_i;
  assign wb_a.flat   = wb_adr_i;

  //////////////////////////////////////////////////
  // port priority: fill, evict, lookup, write buffer
  assign evict_go = evict_req_i & ~fill_i;
  assign rd_go    = rd_req_i & ~fill_i & ~evict_req_i;
  assign wb_go    = wb_we_i & ~rd_req_i & ~fill_i & ~evict_req_i;  // dropped under a read

  always_comb
  begin
    if (fill_i)           ram_idx_o = fill_a.f.idx;
    else if (evict_req_i) ram_idx_o = evict_idx_i;
    else if (rd_req_i)    ram_idx_o = rd_a.f.idx;
    else                  ram_idx_o = wb_a.f.idx;
  end

  assign tag_we_o     = fill_way_i & {cache_mem_pkg::WAYS{fill_i}};  // tags only change on fill
  assign dat_we_o     = tag_we_o | (wb_way_i & {cache_mem_pkg::WAYS{wb_go}});
  assign dat_sel_wb_o = wb_go;
  assign fill_tag_o   = fill_a.f.tag;

  // word byte enables placed at the word slot, full line on fill
  always_comb
  begin
    dat_be_o = '1;
    if (wb_go)
    begin
      for (int w = 0; w < 2**cache_mem_pkg::WORD_OFFS_BITS; w++)
      begin
        dat_be_o[w*(cache_mem_pkg::XLEN/8) +: cache_mem_pkg::XLEN/8] =
          (wb_a.f.word == w) ? wb_be_i : '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // line up with the ram read data
  always_ff @(posedge clk_i)
  begin
    lookup_tag_o  <= rd_a.f.tag;
    evict_way_q_o <= evict_way_i;
    evict_idx_q_o <= evict_idx_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      latch_rd_o    <= 1'b0;
      latch_evict_o <= 1'b0;
    end
    else
    begin
      latch_rd_o    <= rd_go;     // results at next edge
      latch_evict_o <= evict_go;
    end
  end

endmodule

// File: src/sp_ram.sv
`timescale 1ns/1ps

module sp_ram #(
  parameter int ABITS = 4,
  parameter int DBITS = 32
) (
  input  logic                   clk_i,
  input  logic [ABITS-1:0]       addr_i,
  input  logic                   we_i,
  input  logic [(DBITS+7)/8-1:0] be_i,   // one bit per byte, last may be partial
  input  logic [DBITS-1:0]       din_i,
  output logic [DBITS-1:0]       dout_o
);

  logic [DBITS-1:0] mem_q [2**ABITS];

  // single port, read-first
  // write is masked per bit from the byte enables
  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      for (int n = 0; n < DBITS; n++)
      begin
        if (be_i[n/8])
        begin
          mem_q[addr_i][n] <= din_i[n];
        end
      end
    end
    dout_o <= mem_q[addr_i];  // old data on a write
  end

endmodule

// File: src/cache_mem_pkg.sv
package cache_mem_pkg;

  // cpu side
  localparam int XLEN           = 32;
  localparam int PLEN           = 32;           // physical address

  // geometry, 2 ways x 16 sets x 16 byte lines
  localparam int WAYS           = 2;
  localparam int SETS           = 16;
  localparam int IDX_BITS       = 4;            // log2(SETS)
  localparam int BLK_BITS       = 128;          // one line
  localparam int BLK_BYTES      = BLK_BITS / 8;
  localparam int OFFS_BITS      = 4;            // byte in line
  localparam int WORD_OFFS_BITS = 2;            // word in line
  localparam int TAG_BITS       = PLEN - IDX_BITS - OFFS_BITS;

  //////////////////////////////////////////////////
  // address fields, msb first
  typedef struct packed {
    logic [TAG_BITS-1:0]                 tag;
    logic [IDX_BITS-1:0]                 idx;      // set
    logic [WORD_OFFS_BITS-1:0]           word;     // word in line
    logic [OFFS_BITS-WORD_OFFS_BITS-1:0] byte_sel; // byte in word
  } cache_addr_s;

  // same word seen flat or split into fields
  typedef union packed {
    logic [PLEN-1:0] flat;
    cache_addr_s     f;
  } cache_addr_u;

endpackage
